//--- hw/aluCtrlDecoder.sv
`timescale 1ns/1ps
`include "decodeConfig_config.svh"
`default_nettype none

module aluCtrlDecoder import decodePkg::*; (
	input  opcodeT   op,
	input  functT    funct,
	output aluOpT    aluOp,
	output logic     shamtSel,
	output extOpT    extOp,
	output mulDivOpT mulDivOp,
	output logic     hiLoWr,
	output hiLoSelT  hiLoSel,
	output logic     hiLoRdHi
);

	always_comb begin
		aluOp = 4'd15;
		case (op)
			`OP_RTYPE: begin
				case (funct)
					`FN_ADD:            aluOp = 4'd0;
					`FN_ADDU:           aluOp = 4'd11;
					`FN_SUB:            aluOp = 4'd1;
					`FN_SUBU:           aluOp = 4'd12;
					`FN_OR:             aluOp = 4'd2;
					`FN_AND:            aluOp = 4'd3;
					`FN_NOR:            aluOp = 4'd4;
					`FN_XOR:            aluOp = 4'd5;
					`FN_SLL, `FN_SLLV:  aluOp = 4'd6;
					`FN_SRL, `FN_SRLV:  aluOp = 4'd7;
					`FN_SRA, `FN_SRAV:  aluOp = 4'd8;
					`FN_SLT:            aluOp = 4'd9;
					`FN_SLTU:           aluOp = 4'd10;
					default:            aluOp = 4'd15;
				endcase
			end
			`OP_ADDI:  aluOp = 4'd0;
			`OP_ADDIU: aluOp = 4'd11;
			`OP_ORI:   aluOp = 4'd2;
			`OP_ANDI:  aluOp = 4'd3;
			`OP_XORI:  aluOp = 4'd5;
			`OP_SLTI:  aluOp = 4'd9;
			`OP_SLTIU: aluOp = 4'd10;
			`OP_LB, `OP_LH, `OP_LW, `OP_LBU, `OP_LHU,
			`OP_SB, `OP_SH, `OP_SW: aluOp = 4'd0; // Address add
			default: aluOp = 4'd15;
		endcase
	end

	always_comb begin
		case (op)
			`OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU,
			`OP_LB, `OP_LH, `OP_LW, `OP_LBU, `OP_LHU,
			`OP_SB, `OP_SH, `OP_SW: extOp = 2'd1;
			`OP_LUI: extOp = 2'd2;
			default: extOp = 2'd0; // Logic immediates too
		endcase
	end

	// Constant shifts take shamt, the V forms take rs
	assign shamtSel = (op == `OP_RTYPE) &&
		(funct == `FN_SLL || funct == `FN_SRL || funct == `FN_SRA);

	always_comb begin
		mulDivOp = 2'd0;
		hiLoWr = 1'b0;
		hiLoSel = 2'd0;
		hiLoRdHi = 1'b0;
		if (op == `OP_RTYPE) begin
			case (funct)
				`FN_MULTU, `FN_MULT, `FN_DIVU, `FN_DIV: begin
					mulDivOp = {funct[1], ~funct[0]}; // Low funct bits order the unit ops
					hiLoWr = 1'b1;
					hiLoSel = 2'd2;
				end
				`FN_MTHI: begin
					hiLoWr = 1'b1;
					hiLoSel = 2'd1;
				end
				`FN_MTLO: hiLoWr = 1'b1;
				`FN_MFHI: hiLoRdHi = 1'b1;
				default: hiLoWr = 1'b0;
			endcase
		end
	end

	always_comb begin
		if (op == `OP_RTYPE)
			assert final (!(hiLoWr && aluOp != 4'd15))
				else $error("HI/LO write together with ALU op %0d", aluOp);
	end

endmodule

`default_nettype wire

//--- hw/branchResolver.sv
`timescale 1ns/1ps
`include "decodeConfig_config.svh"
`default_nettype none

module branchResolver import decodePkg::*; (
	input  opcodeT  op,
	input  functT   funct,
	input  regIdxT  rt,
	input  logic    cmpNotEqual,
	input  cmpSignT cmpSign,
	output npcOpT   npcOp,
	output logic    isBranch,
	output logic    branchOrJump,
	output logic    isJumpIndex
);

	logic condBranch;
	logic taken;
	logic jumpReg;

	always_comb begin
		condBranch = 1'b0;
		taken = 1'b0;
		case (op)
			`OP_BEQ: begin
				condBranch = 1'b1;
				taken = !cmpNotEqual;
			end
			`OP_BNE: begin
				condBranch = 1'b1;
				taken = cmpNotEqual;
			end
			`OP_BLEZ: begin
				condBranch = 1'b1;
				taken = (cmpSign != 2'd1); // Zero or negative
			end
			`OP_BGTZ: begin
				condBranch = 1'b1;
				taken = (cmpSign == 2'd1);
			end
			`OP_REGIMM: begin
				case (rt)
					`RT_BGEZ, `RT_BGEZAL: begin
						condBranch = 1'b1;
						taken = (cmpSign != 2'd2);
					end
					`RT_BLTZ, `RT_BLTZAL: begin
						condBranch = 1'b1;
						taken = (cmpSign == 2'd2);
					end
					default: condBranch = 1'b0; // Unknown rt is no branch
				endcase
			end
			default: condBranch = 1'b0;
		endcase
	end

	assign jumpReg = (op == `OP_RTYPE) && (funct == `FN_JR || funct == `FN_JALR);
	assign isJumpIndex = (op == `OP_J) || (op == `OP_JAL);

	always_comb begin
		if (condBranch)
			npcOp = taken ? 2'd1 : 2'd0;
		else if (isJumpIndex)
			npcOp = 2'd2;
		else if (jumpReg)
			npcOp = 2'd3;
		else
			npcOp = 2'd0;
	end

	assign isBranch = condBranch || isJumpIndex || jumpReg;
	assign branchOrJump = condBranch || jumpReg;

	always_comb begin
		assert final (isBranch || npcOp == 2'd0)
			else $error("Non-sequential next PC %0d for a non-branch", npcOp);
	end

endmodule

`default_nettype wire

//--- hw/ctrlDecodeTop.sv
`timescale 1ns/1ps
`default_nettype none

module ctrlDecodeTop import decodePkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic [31:0] instr,
	input  logic        instrValid,
	input  logic        cmpNotEqual,
	input  logic        upstreamExc,
	input  logic        flush,
	input  cmpSignT     cmpSign,
	input  excCodeT     upstreamExcCode,
	output logic        outValid,
	output aluOpT       aluOpQ,
	output logic        shamtSelQ,
	output extOpT       extOpQ,
	output mulDivOpT    mulDivOpQ,
	output logic        hiLoWrQ,
	output hiLoSelT     hiLoSelQ,
	output logic        hiLoRdHiQ,
	output logic        memRdQ,
	output logic        memWrQ,
	output memSizeT     memSizeQ,
	output logic        regWrQ,
	output destSelT     destSelQ,
	output wbSrcT       wbSrcQ,
	output npcOpT       npcOpQ,
	output logic        isBranchQ,
	output logic        branchOrJumpQ,
	output logic        excQ,
	output excCodeT     excCodeQ
);

	opcodeT op;
	functT funct;
	regIdxT rt;

	aluOpT aluOp;
	logic shamtSel;
	extOpT extOp;
	mulDivOpT mulDivOp;
	logic hiLoWr;
	hiLoSelT hiLoSel;
	logic hiLoRdHi;
	logic memRd;
	logic memWr;
	memSizeT memSize;
	logic regWr;
	destSelT destSel;
	wbSrcT wbSrc;
	npcOpT npcOp;
	logic isBranch;
	logic branchOrJump;
	logic isJumpIndex; // Only feeds the reserved check
	logic exc;
	excCodeT excCode;

	assign op = instr[31:26];
	assign rt = instr[20:16]; // Also the REGIMM branch kind
	assign funct = instr[5:0];

	aluCtrlDecoder uAlu (.op(op), .funct(funct), .aluOp(aluOp), .shamtSel(shamtSel),
		.extOp(extOp), .mulDivOp(mulDivOp), .hiLoWr(hiLoWr), .hiLoSel(hiLoSel),
		.hiLoRdHi(hiLoRdHi));

	memCtrlDecoder uMem (.op(op), .memRd(memRd), .memWr(memWr), .memSize(memSize));

	writebackDecoder uWb (.op(op), .funct(funct), .rt(rt), .regWr(regWr),
		.destSel(destSel), .wbSrc(wbSrc));

	branchResolver uBranch (.op(op), .funct(funct), .rt(rt), .cmpNotEqual(cmpNotEqual),
		.cmpSign(cmpSign), .npcOp(npcOp), .isBranch(isBranch),
		.branchOrJump(branchOrJump), .isJumpIndex(isJumpIndex));

	exceptionChecker uExc (.clk(clk), .rst(rst), .op(op), .funct(funct), .regWr(regWr),
		.hiLoWr(hiLoWr), .memWr(memWr), .branchOrJump(branchOrJump),
		.isJumpIndex(isJumpIndex), .upstreamExc(upstreamExc), .flush(flush),
		.upstreamExcCode(upstreamExcCode), .exc(exc), .excCode(excCode));

	decodeStageReg uStage (.clk(clk), .rst(rst), .instrValid(instrValid), .flush(flush),
		.aluOp(aluOp), .shamtSel(shamtSel), .extOp(extOp), .mulDivOp(mulDivOp),
		.hiLoWr(hiLoWr), .hiLoSel(hiLoSel), .hiLoRdHi(hiLoRdHi), .memRd(memRd),
		.memWr(memWr), .memSize(memSize), .regWr(regWr), .destSel(destSel),
		.wbSrc(wbSrc), .npcOp(npcOp), .isBranch(isBranch), .branchOrJump(branchOrJump),
		.exc(exc), .excCode(excCode), .outValid(outValid), .aluOpQ(aluOpQ),
		.shamtSelQ(shamtSelQ), .extOpQ(extOpQ), .mulDivOpQ(mulDivOpQ),
		.hiLoWrQ(hiLoWrQ), .hiLoSelQ(hiLoSelQ), .hiLoRdHiQ(hiLoRdHiQ),
		.memRdQ(memRdQ), .memWrQ(memWrQ), .memSizeQ(memSizeQ), .regWrQ(regWrQ),
		.destSelQ(destSelQ), .wbSrcQ(wbSrcQ), .npcOpQ(npcOpQ), .isBranchQ(isBranchQ),
		.branchOrJumpQ(branchOrJumpQ), .excQ(excQ), .excCodeQ(excCodeQ));

endmodule

`default_nettype wire

//--- hw/decodeConfig_config.svh
`ifndef DECODE_CONFIG_SVH
`define DECODE_CONFIG_SVH

// Primary opcodes, instr[31:26]
`define OP_RTYPE  6'b000000
`define OP_REGIMM 6'b000001 // Branch kind sits in rt
`define OP_J      6'b000010
`define OP_JAL    6'b000011
`define OP_BEQ    6'b000100
`define OP_BNE    6'b000101
`define OP_BLEZ   6'b000110
`define OP_BGTZ   6'b000111
`define OP_ADDI   6'b001000
`define OP_ADDIU  6'b001001
`define OP_SLTI   6'b001010
`define OP_SLTIU  6'b001011
`define OP_ANDI   6'b001100
`define OP_ORI    6'b001101
`define OP_XORI   6'b001110
`define OP_LUI    6'b001111
`define OP_LB     6'b100000
`define OP_LH     6'b100001
`define OP_LW     6'b100011
`define OP_LBU    6'b100100
`define OP_LHU    6'b100101
`define OP_SB     6'b101000
`define OP_SH     6'b101001
`define OP_SW     6'b101011

// Function codes for the R-type opcode, instr[5:0]
`define FN_SLL     6'b000000
`define FN_SRL     6'b000010
`define FN_SRA     6'b000011
`define FN_SLLV    6'b000100
`define FN_SRLV    6'b000110
`define FN_SRAV    6'b000111
`define FN_JR      6'b001000
`define FN_JALR    6'b001001
`define FN_SYSCALL 6'b001100
`define FN_BREAK   6'b001101
`define FN_MFHI    6'b010000
`define FN_MTHI    6'b010001
`define FN_MFLO    6'b010010
`define FN_MTLO    6'b010011
`define FN_MULT    6'b011000
`define FN_MULTU   6'b011001
`define FN_DIV     6'b011010
`define FN_DIVU    6'b011011
`define FN_ADD     6'b100000
`define FN_ADDU    6'b100001
`define FN_SUB     6'b100010
`define FN_SUBU    6'b100011
`define FN_AND     6'b100100
`define FN_OR      6'b100101
`define FN_XOR     6'b100110
`define FN_NOR     6'b100111
`define FN_SLT     6'b101010
`define FN_SLTU    6'b101011

// REGIMM branch kinds, instr[20:16]
`define RT_BLTZ   5'b00000
`define RT_BGEZ   5'b00001
`define RT_BLTZAL 5'b10000
`define RT_BGEZAL 5'b10001

// Exception codes
`define EXC_SYS 5'd8
`define EXC_BP  5'd9
`define EXC_RI  5'd10

`endif

//--- hw/decodePkg.sv
`default_nettype none

package decodePkg;

	typedef logic [5:0] opcodeT;
	typedef logic [5:0] functT;
	typedef logic [4:0] regIdxT;

	// 15 = no ALU operation
	typedef logic [3:0] aluOpT;

	// MULTU 0, MULT 1, DIVU 2, DIV 3
	typedef logic [1:0] mulDivOpT;

	// Zero 0, sign 1, upper 2
	typedef logic [1:0] extOpT;

	// LO from rs 0, HI from rs 1, product or quotient 2
	typedef logic [1:0] hiLoSelT;

	// SB 0, SH 1, SW 2, LBU 3, LB 4, LHU 5, LH 6, LW or none 7
	typedef logic [2:0] memSizeT;

	// Sequential 0, branch target 1, jump index 2, register 3
	typedef logic [1:0] npcOpT;

	typedef logic [1:0] destSelT; // rt 0, rd 1, link 2

	// HI/LO 0, upper immediate 1, ALU 2, link address 3, memory 4
	typedef logic [2:0] wbSrcT;

	typedef logic [4:0] excCodeT;
	typedef logic [1:0] cmpSignT; // rs zero 0, positive 1, negative 2

endpackage

`default_nettype wire

//--- hw/decodeStageReg.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStageReg import decodePkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     instrValid,
	input  logic     flush,
	input  aluOpT    aluOp,
	input  logic     shamtSel,
	input  extOpT    extOp,
	input  mulDivOpT mulDivOp,
	input  logic     hiLoWr,
	input  hiLoSelT  hiLoSel,
	input  logic     hiLoRdHi,
	input  logic     memRd,
	input  logic     memWr,
	input  memSizeT  memSize,
	input  logic     regWr,
	input  destSelT  destSel,
	input  wbSrcT    wbSrc,
	input  npcOpT    npcOp,
	input  logic     isBranch,
	input  logic     branchOrJump,
	input  logic     exc,
	input  excCodeT  excCode,
	output logic     outValid,
	output aluOpT    aluOpQ,
	output logic     shamtSelQ,
	output extOpT    extOpQ,
	output mulDivOpT mulDivOpQ,
	output logic     hiLoWrQ,
	output hiLoSelT  hiLoSelQ,
	output logic     hiLoRdHiQ,
	output logic     memRdQ,
	output logic     memWrQ,
	output memSizeT  memSizeQ,
	output logic     regWrQ,
	output destSelT  destSelQ,
	output wbSrcT    wbSrcQ,
	output npcOpT    npcOpQ,
	output logic     isBranchQ,
	output logic     branchOrJumpQ,
	output logic     excQ,
	output excCodeT  excCodeQ
);

	logic capture;

	assign capture = instrValid && !flush;

	always_ff @(posedge clk) begin
		if (!rst || !capture) begin // A squashed slot looks like reset
			{outValid, aluOpQ, shamtSelQ, extOpQ, mulDivOpQ} <= '0;
			{hiLoWrQ, hiLoSelQ, hiLoRdHiQ, memRdQ, memWrQ, memSizeQ} <= '0;
			{regWrQ, destSelQ, wbSrcQ, npcOpQ, isBranchQ, branchOrJumpQ} <= '0;
			{excQ, excCodeQ} <= '0;
		end else begin
			{outValid, aluOpQ, shamtSelQ, extOpQ, mulDivOpQ} <=
				{1'b1, aluOp, shamtSel, extOp, mulDivOp};
			{hiLoWrQ, hiLoSelQ, hiLoRdHiQ, memRdQ, memWrQ, memSizeQ} <=
				{hiLoWr, hiLoSel, hiLoRdHi, memRd, memWr, memSize};
			{regWrQ, destSelQ, wbSrcQ, npcOpQ, isBranchQ, branchOrJumpQ} <=
				{regWr, destSel, wbSrc, npcOp, isBranch, branchOrJump};
			{excQ, excCodeQ} <= {exc, excCode};
		end
	end

	// One instruction never targets both the register file and HI/LO
	oneWriteTarget: assert property (@(posedge clk) disable iff (!rst)
		capture |-> !(regWr && hiLoWr))
		else $error("Instruction writes both the register file and HI/LO");

endmodule

`default_nettype wire

//--- hw/exceptionChecker.sv
`timescale 1ns/1ps
`include "decodeConfig_config.svh"
`default_nettype none

module exceptionChecker import decodePkg::*; (
	input  logic    clk,
	input  logic    rst,
	input  opcodeT  op,
	input  functT   funct,
	input  logic    regWr,
	input  logic    hiLoWr,
	input  logic    memWr,
	input  logic    branchOrJump,
	input  logic    isJumpIndex,
	input  logic    upstreamExc,
	input  logic    flush,
	input  excCodeT upstreamExcCode,
	output logic    exc,
	output excCodeT excCode
);

	logic afterReset; // High for the first cycle out of reset
	logic isBreak;
	logic isSyscall;
	logic recognised;

	always_ff @(posedge clk) begin
		if (!rst)
			afterReset <= 1'b1;
		else
			afterReset <= 1'b0;
	end

	assign isBreak = (op == `OP_RTYPE) && (funct == `FN_BREAK);
	assign isSyscall = (op == `OP_RTYPE) && (funct == `FN_SYSCALL);

	// Every kept instruction has at least one of these effects
	assign recognised = regWr || hiLoWr || memWr || isBreak || isSyscall ||
		branchOrJump || isJumpIndex;

	always_comb begin
		exc = 1'b1;
		if (upstreamExc)
			excCode = upstreamExcCode; // Earlier stage wins
		else if (!recognised && !afterReset && !flush)
			excCode = `EXC_RI;
		else if (isBreak)
			excCode = `EXC_BP;
		else if (isSyscall)
			excCode = `EXC_SYS;
		else begin
			exc = 1'b0;
			excCode = 5'd0;
		end
	end

endmodule

`default_nettype wire

//--- hw/memCtrlDecoder.sv
`timescale 1ns/1ps
`include "decodeConfig_config.svh"
`default_nettype none

module memCtrlDecoder import decodePkg::*; (
	input  opcodeT  op,
	output logic    memRd,
	output logic    memWr,
	output memSizeT memSize
);

	always_comb begin
		memRd = 1'b0;
		memWr = 1'b0;
		memSize = 3'd7; // Word, also the idle value
		case (op)
			`OP_SB: begin
				memWr = 1'b1;
				memSize = 3'd0;
			end
			`OP_SH: begin
				memWr = 1'b1;
				memSize = 3'd1;
			end
			`OP_SW: begin
				memWr = 1'b1;
				memSize = 3'd2;
			end
			`OP_LBU: begin
				memRd = 1'b1;
				memSize = 3'd3;
			end
			`OP_LB: begin
				memRd = 1'b1;
				memSize = 3'd4;
			end
			`OP_LHU: begin
				memRd = 1'b1;
				memSize = 3'd5;
			end
			`OP_LH: begin
				memRd = 1'b1;
				memSize = 3'd6;
			end
			`OP_LW: memRd = 1'b1;
			default: memRd = 1'b0;
		endcase
	end

	always_comb begin
		assert final (!(memRd && memWr))
			else $error("Load and store decoded together for opcode %0h", op);
	end

endmodule

`default_nettype wire

//--- hw/writebackDecoder.sv
`timescale 1ns/1ps
`include "decodeConfig_config.svh"
`default_nettype none

module writebackDecoder import decodePkg::*; (
	input  opcodeT  op,
	input  functT   funct,
	input  regIdxT  rt,
	output logic    regWr,
	output destSelT destSel,
	output wbSrcT   wbSrc
);

	always_comb begin
		regWr = 1'b0;
		destSel = 2'd0; // rt for I-type
		wbSrc = 3'd2; // ALU result
		case (op)
			`OP_RTYPE: begin
				destSel = 2'd1;
				case (funct)
					`FN_ADD, `FN_ADDU, `FN_SUB, `FN_SUBU,
					`FN_AND, `FN_OR, `FN_NOR, `FN_XOR,
					`FN_SLL, `FN_SRL, `FN_SRA,
					`FN_SLLV, `FN_SRLV, `FN_SRAV,
					`FN_SLT, `FN_SLTU: regWr = 1'b1;
					`FN_JALR: begin
						regWr = 1'b1;
						wbSrc = 3'd3;
					end
					`FN_MFHI, `FN_MFLO: begin
						regWr = 1'b1;
						wbSrc = 3'd0;
					end
					`FN_MULT, `FN_MULTU, `FN_DIV, `FN_DIVU: wbSrc = 3'd0;
					default: regWr = 1'b0;
				endcase
			end
			`OP_REGIMM: begin
				destSel = 2'd2; // r31
				wbSrc = 3'd3;
				regWr = (rt == `RT_BGEZAL) || (rt == `RT_BLTZAL); // Linking forms only
			end
			`OP_JAL: begin
				regWr = 1'b1;
				destSel = 2'd2;
				wbSrc = 3'd3;
			end
			`OP_LUI: begin
				regWr = 1'b1;
				wbSrc = 3'd1;
			end
			`OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU,
			`OP_ANDI, `OP_ORI, `OP_XORI: regWr = 1'b1;
			`OP_LB, `OP_LH, `OP_LW, `OP_LBU, `OP_LHU: begin
				regWr = 1'b1;
				wbSrc = 3'd4;
			end
			default: regWr = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

//--- test/ctrlDecodeChecker.sv
`timescale 1ns/1ps
`include "decodeConfig_config.svh"
`default_nettype none

module ctrlDecodeChecker import decodePkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic [31:0] instr,
	input  logic        instrValid,
	input  logic        flush,
	input  logic        cmpNotEqual,
	input  cmpSignT     cmpSign,
	input  logic        upstreamExc,
	input  excCodeT     upstreamExcCode,
	input  logic        outValid,
	input  aluOpT       aluOpQ,
	input  logic        shamtSelQ,
	input  extOpT       extOpQ,
	input  mulDivOpT    mulDivOpQ,
	input  logic        hiLoWrQ,
	input  hiLoSelT     hiLoSelQ,
	input  logic        hiLoRdHiQ,
	input  logic        memRdQ,
	input  logic        memWrQ,
	input  memSizeT     memSizeQ,
	input  logic        regWrQ,
	input  destSelT     destSelQ,
	input  wbSrcT       wbSrcQ,
	input  npcOpT       npcOpQ,
	input  logic        isBranchQ,
	input  logic        branchOrJumpQ,
	input  logic        excQ,
	input  excCodeT     excCodeQ,
	output int          errorCount,
	output int          checkCount
);

	logic [31:0] instrS; // Inputs as sampled at the last rising edge
	logic validS;
	logic flushS;
	logic rstS;
	logic cmpNeS;
	cmpSignT signS;
	logic upExcS;
	excCodeT upCodeS;
	logic afterReset;
	logic afterResetS;
	logic primed = 1'b0;
	logic capture;

	opcodeT op;
	functT funct;
	regIdxT rt;

	aluOpT mAlu;
	logic mShamt;
	extOpT mExt;
	mulDivOpT mMulDiv;
	logic mHiLoWr;
	hiLoSelT mHiLoSel;
	logic mRdHi;
	logic mMemRd;
	logic mMemWr;
	memSizeT mSize;
	logic mRegWr;
	destSelT mDest;
	wbSrcT mWb;
	logic mCond;
	logic mTaken;
	logic mJumpIdx;
	logic mJumpReg;
	logic mBrk;
	logic mSys;
	logic mIsBranch;
	logic mBrOrJ;
	npcOpT mNpc;
	logic recognised;
	logic mExc;
	excCodeT mExcCode;

	function automatic aluOpT rTypeAlu(input functT f);
		case (f)
			`FN_ADD: return 4'd0;
			`FN_SUB: return 4'd1;
			`FN_OR: return 4'd2;
			`FN_AND: return 4'd3;
			`FN_NOR: return 4'd4;
			`FN_XOR: return 4'd5;
			`FN_SLL, `FN_SLLV: return 4'd6;
			`FN_SRL, `FN_SRLV: return 4'd7;
			`FN_SRA, `FN_SRAV: return 4'd8;
			`FN_SLT: return 4'd9;
			`FN_SLTU: return 4'd10;
			`FN_ADDU: return 4'd11;
			`FN_SUBU: return 4'd12;
			default: return 4'd15; // Not an ALU instruction
		endcase
	endfunction

	function automatic aluOpT immAlu(input opcodeT o);
		case (o)
			`OP_ADDI: return 4'd0;
			`OP_ORI: return 4'd2;
			`OP_ANDI: return 4'd3;
			`OP_XORI: return 4'd5;
			`OP_SLTI: return 4'd9;
			`OP_SLTIU: return 4'd10;
			`OP_ADDIU: return 4'd11;
			default: return 4'd15;
		endcase
	endfunction

	function automatic memSizeT memKind(input opcodeT o);
		case (o)
			`OP_SB: return 3'd0;
			`OP_SH: return 3'd1;
			`OP_SW: return 3'd2;
			`OP_LBU: return 3'd3;
			`OP_LB: return 3'd4;
			`OP_LHU: return 3'd5;
			`OP_LH: return 3'd6;
			default: return 3'd7; // LW
		endcase
	endfunction

	function automatic mulDivOpT unitOp(input functT f);
		case (f)
			`FN_MULT: return 2'd1;
			`FN_DIVU: return 2'd2;
			`FN_DIV: return 2'd3;
			default: return 2'd0; // MULTU
		endcase
	endfunction

	function automatic logic [31:0] kept(input logic [31:0] value);
		return capture ? value : 32'd0;
	endfunction

	task automatic compareField(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("[FAIL] %s for instr %08h: expected %0d, actual %0d",
				name, instrS, expected, actual);
		end
	endtask

	initial begin
		errorCount = 0;
		checkCount = 0;
	end

	always @(posedge clk) begin
		instrS <= instr;
		validS <= instrValid;
		flushS <= flush;
		rstS <= rst;
		cmpNeS <= cmpNotEqual;
		signS <= cmpSign;
		upExcS <= upstreamExc;
		upCodeS <= upstreamExcCode;
		afterResetS <= afterReset;
		afterReset <= !rst; // High in the first cycle out of reset
		primed <= 1'b1;
	end

	assign op = instrS[31:26];
	assign rt = instrS[20:16];
	assign funct = instrS[5:0];
	assign capture = rstS && validS && !flushS;

	always_comb begin
		mAlu = 4'd15;
		mShamt = 1'b0;
		mExt = 2'd0;
		mMulDiv = 2'd0;
		mHiLoWr = 1'b0;
		mHiLoSel = 2'd0;
		mRdHi = 1'b0;
		mMemRd = 1'b0;
		mMemWr = 1'b0;
		mSize = 3'd7;
		mRegWr = 1'b0;
		mDest = 2'd0;
		mWb = 3'd2;
		mCond = 1'b0;
		mTaken = 1'b0;
		mJumpIdx = 1'b0;
		mJumpReg = 1'b0;
		mBrk = 1'b0;
		mSys = 1'b0;
		case (op)
			`OP_RTYPE: begin
				mAlu = rTypeAlu(funct);
				mRegWr = (mAlu != 4'd15);
				mDest = 2'd1;
				mShamt = (funct == `FN_SLL) || (funct == `FN_SRL) || (funct == `FN_SRA);
				case (funct)
					`FN_MFHI: begin
						mRegWr = 1'b1;
						mWb = 3'd0;
						mRdHi = 1'b1;
					end
					`FN_MFLO: begin
						mRegWr = 1'b1;
						mWb = 3'd0;
					end
					`FN_MTHI: begin
						mHiLoWr = 1'b1;
						mHiLoSel = 2'd1;
					end
					`FN_MTLO: mHiLoWr = 1'b1;
					`FN_MULTU, `FN_MULT, `FN_DIVU, `FN_DIV: begin
						mHiLoWr = 1'b1;
						mHiLoSel = 2'd2;
						mMulDiv = unitOp(funct);
					end
					`FN_JR: mJumpReg = 1'b1;
					`FN_JALR: begin
						mJumpReg = 1'b1;
						mRegWr = 1'b1;
						mWb = 3'd3;
					end
					`FN_BREAK: mBrk = 1'b1;
					`FN_SYSCALL: mSys = 1'b1;
					default: ;
				endcase
			end
			`OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU: begin
				mAlu = immAlu(op);
				mExt = 2'd1;
				mRegWr = 1'b1;
			end
			`OP_ANDI, `OP_ORI, `OP_XORI: begin
				mAlu = immAlu(op); // Zero extended
				mRegWr = 1'b1;
			end
			`OP_LUI: begin
				mExt = 2'd2;
				mRegWr = 1'b1;
				mWb = 3'd1;
			end
			`OP_LB, `OP_LH, `OP_LW, `OP_LBU, `OP_LHU: begin
				mAlu = 4'd0;
				mExt = 2'd1;
				mMemRd = 1'b1;
				mSize = memKind(op);
				mRegWr = 1'b1;
				mWb = 3'd4;
			end
			`OP_SB, `OP_SH, `OP_SW: begin
				mAlu = 4'd0;
				mExt = 2'd1;
				mMemWr = 1'b1;
				mSize = memKind(op);
			end
			`OP_BEQ: begin
				mCond = 1'b1;
				mTaken = !cmpNeS;
			end
			`OP_BNE: begin
				mCond = 1'b1;
				mTaken = cmpNeS;
			end
			`OP_BLEZ: begin
				mCond = 1'b1;
				mTaken = (signS == 2'd0) || (signS == 2'd2);
			end
			`OP_BGTZ: begin
				mCond = 1'b1;
				mTaken = (signS == 2'd1);
			end
			`OP_REGIMM: begin
				mCond = (rt == `RT_BLTZ) || (rt == `RT_BGEZ) ||
					(rt == `RT_BLTZAL) || (rt == `RT_BGEZAL);
				if (rt == `RT_BGEZ || rt == `RT_BGEZAL)
					mTaken = (signS == 2'd0) || (signS == 2'd1);
				else
					mTaken = (signS == 2'd2);
				if (rt == `RT_BLTZAL || rt == `RT_BGEZAL) begin
					mRegWr = 1'b1; // Link into r31
					mDest = 2'd2;
					mWb = 3'd3;
				end
			end
			`OP_J: mJumpIdx = 1'b1;
			`OP_JAL: begin
				mJumpIdx = 1'b1;
				mRegWr = 1'b1;
				mDest = 2'd2;
				mWb = 3'd3;
			end
			default: ;
		endcase
	end

	assign mIsBranch = mCond || mJumpIdx || mJumpReg;
	assign mBrOrJ = mCond || mJumpReg;
	assign mNpc = (mCond && mTaken) ? 2'd1 : mJumpIdx ? 2'd2 : mJumpReg ? 2'd3 : 2'd0;
	assign recognised = mRegWr || mHiLoWr || mMemWr || mBrk || mSys || mIsBranch;

	always_comb begin
		mExc = 1'b1;
		mExcCode = 5'd0;
		if (upExcS)
			mExcCode = upCodeS;
		else if (!recognised && !afterResetS && !flushS)
			mExcCode = `EXC_RI;
		else if (mBrk)
			mExcCode = `EXC_BP;
		else if (mSys)
			mExcCode = `EXC_SYS;
		else
			mExc = 1'b0;
	end

	// Outputs settle after the rising edge, so compare on the falling one
	always @(negedge clk) begin
		if (primed) begin
			compareField("outValid", capture, outValid);
			compareField("aluOp", kept(mAlu), aluOpQ);
			compareField("shamtSel", kept(mShamt), shamtSelQ);
			compareField("extOp", kept(mExt), extOpQ);
			compareField("mulDivOp", kept(mMulDiv), mulDivOpQ);
			compareField("hiLoWr", kept(mHiLoWr), hiLoWrQ);
			compareField("hiLoSel", kept(mHiLoSel), hiLoSelQ);
			compareField("hiLoRdHi", kept(mRdHi), hiLoRdHiQ);
			compareField("memRd", kept(mMemRd), memRdQ);
			compareField("memWr", kept(mMemWr), memWrQ);
			compareField("memSize", kept(mSize), memSizeQ);
			compareField("regWr", kept(mRegWr), regWrQ);
			compareField("npcOp", kept(mNpc), npcOpQ);
			compareField("isBranch", kept(mIsBranch), isBranchQ);
			compareField("branchOrJump", kept(mBrOrJ), branchOrJumpQ);
			compareField("exc", kept(mExc), excQ);
			compareField("excCode", kept(mExcCode), excCodeQ);
			if (!capture || mRegWr) begin // Free in a live slot that writes no register
				compareField("destSel", kept(mDest), destSelQ);
				compareField("wbSrc", kept(mWb), wbSrcQ);
			end
		end
	end

endmodule

`default_nettype wire

//--- test/ctrlDecodeTb.sv
`timescale 1ns/1ps
`include "decodeConfig_config.svh"
`default_nettype none

module ctrlDecodeTb import decodePkg::*; ();

	logic clk;
	logic rst;
	logic [31:0] instr;
	logic instrValid;
	logic flush;
	logic cmpNotEqual;
	cmpSignT cmpSign;
	logic upstreamExc;
	excCodeT upstreamExcCode;

	logic outValid;
	aluOpT aluOpQ;
	logic shamtSelQ;
	extOpT extOpQ;
	mulDivOpT mulDivOpQ;
	logic hiLoWrQ;
	hiLoSelT hiLoSelQ;
	logic hiLoRdHiQ;
	logic memRdQ;
	logic memWrQ;
	memSizeT memSizeQ;
	logic regWrQ;
	destSelT destSelQ;
	wbSrcT wbSrcQ;
	npcOpT npcOpQ;
	logic isBranchQ;
	logic branchOrJumpQ;
	logic excQ;
	excCodeT excCodeQ;

	int errorCount;
	int checkCount;
	int timeouts;

	logic [31:0] templates[$]; // Fixed bits of each kept encoding
	logic [31:0] fieldMasks[$]; // Bits free for random register fields

	ctrlDecodeTop dut (.*);
	ctrlDecodeChecker refCheck (.*);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	task automatic addEncoding(input logic [31:0] template, input logic [31:0] mask);
		templates.push_back(template);
		fieldMasks.push_back(mask);
	endtask

	// Coprocessor-0 opcode is listed so reserved traps come up often
	task automatic buildTable();
		functT rFuncts [0:27];
		opcodeT iOps [0:22];
		regIdxT rtCodes [0:3];
		rFuncts = '{`FN_SLL, `FN_SRL, `FN_SRA, `FN_SLLV, `FN_SRLV, `FN_SRAV, `FN_JR,
			`FN_JALR, `FN_SYSCALL, `FN_BREAK, `FN_MFHI, `FN_MTHI, `FN_MFLO, `FN_MTLO,
			`FN_MULT, `FN_MULTU, `FN_DIV, `FN_DIVU, `FN_ADD, `FN_ADDU, `FN_SUB, `FN_SUBU,
			`FN_AND, `FN_OR, `FN_XOR, `FN_NOR, `FN_SLT, `FN_SLTU};
		iOps = '{`OP_J, `OP_JAL, `OP_BEQ, `OP_BNE, `OP_BLEZ, `OP_BGTZ, `OP_ADDI,
			`OP_ADDIU, `OP_SLTI, `OP_SLTIU, `OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI,
			`OP_LB, `OP_LH, `OP_LW, `OP_LBU, `OP_LHU, `OP_SB, `OP_SH, `OP_SW, 6'b010000};
		rtCodes = '{`RT_BLTZ, `RT_BGEZ, `RT_BLTZAL, `RT_BGEZAL};
		foreach (rFuncts[i])
			addEncoding({26'd0, rFuncts[i]}, 32'h03ff_ffc0); // rs, rt, rd, shamt
		foreach (iOps[i])
			addEncoding({iOps[i], 26'd0}, 32'h03ff_ffff);
		foreach (rtCodes[i])
			addEncoding({`OP_REGIMM, 5'd0, rtCodes[i], 16'd0}, 32'h03e0_ffff);
	endtask

	task automatic driveRandom();
		int unsigned pick;
		logic [31:0] word;
		word = $urandom;
		if ($urandom_range(1, 0) == 0) begin // Half from the table
			pick = $urandom_range(templates.size() - 1, 0);
			word = templates[pick] | (word & fieldMasks[pick]);
		end
		instr <= word;
		instrValid <= ($urandom_range(7, 0) != 0);
		flush <= ($urandom_range(7, 0) == 0);
		cmpNotEqual <= $urandom_range(1, 0);
		cmpSign <= $urandom_range(2, 0);
		upstreamExc <= ($urandom_range(15, 0) == 0);
		upstreamExcCode <= $urandom_range(31, 0);
	endtask

	initial begin
		int unsigned seed;
		int unsigned discard;
		int drainWait;
		seed = 32'hd026_9a5f;
		discard = $urandom(seed);
		timeouts = 0;
		rst = 1'b0;
		instr = 32'd0;
		instrValid = 1'b0;
		flush = 1'b0;
		cmpNotEqual = 1'b0;
		cmpSign = 2'd0;
		upstreamExc = 1'b0;
		upstreamExcCode = 5'd0;
		buildTable();
		repeat (4) @(posedge clk);
		rst <= 1'b1;
		instr <= 32'h4000_0000; // Coprocessor-0 word in the first slot, no trap expected
		instrValid <= 1'b1;
		repeat (3000) begin
			@(posedge clk);
			driveRandom();
		end
		@(posedge clk);
		instrValid <= 1'b0;
		drainWait = 0;
		@(negedge clk);
		while (outValid !== 1'b0 && drainWait < 10) begin
			@(negedge clk);
			drainWait++;
		end
		if (outValid !== 1'b0) begin
			$display("Timeout: outValid stayed high after the last instruction");
			timeouts++;
		end
		$display("Errors: %0d mismatches, %0d timeouts, %0d comparisons",
			errorCount, timeouts, checkCount);
		if (errorCount == 0 && timeouts == 0 && checkCount > 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+hw
hw/decodePkg.sv
hw/aluCtrlDecoder.sv
hw/memCtrlDecoder.sv
hw/writebackDecoder.sv
hw/branchResolver.sv
hw/exceptionChecker.sv
hw/decodeStageReg.sv
hw/ctrlDecodeTop.sv
test/ctrlDecodeChecker.sv
test/ctrlDecodeTb.sv
